//--- Makefile
# Verilator build for the softmax normaliser testbench

TOP := tb_softmax

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): project.f verilog/*.sv tb/*.sv
	verilator --binary --timing --assert -j 0 -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- project.f
verilog/softmax_pkg.sv
verilog/sync_fifo.sv
verilog/exp_sum.sv
verilog/fxp_div_pipe.sv
verilog/softmax.sv
tb/tb_softmax.sv

//--- tb/tb_softmax.sv
/* Softmax normaliser testbench
   Directed groups against a floor-rule reference model, in-order output check */
`timescale 1ns/1ps

module tb_softmax;

  import softmax_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int RAND_GROUPS = 20;
  // Equal group, single plus full group, mixed group, random groups
  localparam int N_GROUPS    = 1 + 2 + 1 + RAND_GROUPS;
  localparam int WDOG_CYCLES = 200 * N_GROUPS + 50;

  logic        clk;
  logic        rst_n;
  logic        coef_vld;
  coef_beat_t  coef_in;
  logic        alpha_vld;
  alpha_beat_t alpha_out;

  // Expected weights in output order
  alpha_beat_t       exp_q [$];
  logic [COEF_W-1:0] grp_coef [MAX_NODES];
  logic [31:0]       lfsr = 32'hd8e8;
  int                groups_sent = 0;
  int                groups_done = 0;
  int                n_checked = 0;

  softmax dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .coef_vld  (coef_vld),
    .coef_in   (coef_in),
    .alpha_vld (alpha_vld),
    .alpha_out (alpha_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ====================
  // Helpers
  // ====================

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_alpha(input alpha_beat_t got, input alpha_beat_t exp);
    if (got !== exp) begin
      $display("ERR %0t: weight %0d got alpha %h last %b, expected alpha %h last %b",
               $time, n_checked, got.alpha, got.last, exp.alpha, exp.last);
      $display("FAIL: see errors above");
      $fatal(1, "weight mismatch");
    end else begin
      n_checked++;
    end
  endtask

  task automatic check_idle();
    if (alpha_vld) begin
      $display("Unexpected output: alpha_vld high at %0t with no weight pending", $time);
      $display("FAIL: see errors above");
      $fatal(1, "unexpected output");
    end
  endtask

  // Model each weight by the floor rule, then drive the beats gap-free
  task automatic send_group(input int n);
    logic [SUM_W-1:0] sum;
    longint           num;
    alpha_beat_t      exp;
    // Stay within two groups of the outputs
    while (groups_sent - groups_done >= 2) begin
      @(posedge clk);
      coef_vld <= 1'b0;
    end
    sum = '0;
    for (int i = 0; i < n; i++) begin
      sum = sum + (SUM_W'(1) << grp_coef[i]);
    end
    for (int i = 0; i < n; i++) begin
      num       = longint'(1) << (grp_coef[i] + WOF);
      exp.alpha = ALPHA_W'(num / longint'(sum));
      exp.last  = (i == n - 1);
      exp_q.push_back(exp);
    end
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      coef_vld         <= 1'b1;
      coef_in.num_node <= NODE_W'(n);
      coef_in.coef     <= grp_coef[i];
    end
    groups_sent++;
  endtask

  task automatic wait_outputs();
    @(posedge clk);
    coef_vld <= 1'b0;
    while (groups_done != groups_sent) begin
      @(posedge clk);
    end
  endtask

  // Outputs sampled away from the driving edge
  always @(negedge clk) begin
    if (exp_q.size() == 0) begin
      check_idle();
    end else if (alpha_vld) begin
      if (exp_q[0].last) begin
        groups_done++;
      end
      check_alpha(alpha_out, exp_q.pop_front());
    end
  end

  // ====================
  // Tests
  // ====================

  task automatic test_idle_after_reset();
    repeat (30) begin
      @(negedge clk);
      check_idle();
    end
  endtask

  // Four equal terms give 0x2000 each
  task automatic test_equal_group();
    for (int i = 0; i < 4; i++) begin
      grp_coef[i] = 4'd5;
    end
    send_group(4);
    wait_outputs();
  endtask

  task automatic test_single_and_full();
    grp_coef[0] = 4'd9;
    send_group(1);
    for (int i = 0; i < MAX_NODES; i++) begin
      grp_coef[i] = 4'd15;
    end
    send_group(MAX_NODES);
    wait_outputs();
  endtask

  task automatic test_mixed_group();
    grp_coef[0] = 4'd0;
    grp_coef[1] = 4'd3;
    grp_coef[2] = 4'd7;
    send_group(3);
    wait_outputs();
  endtask

  task automatic test_random_groups();
    logic [31:0] r;
    int          n;
    for (int g = 0; g < RAND_GROUPS; g++) begin
      take_bits(4, r);
      n = int'(r[3:0]) + 1;
      for (int i = 0; i < n; i++) begin
        take_bits(COEF_W, r);
        grp_coef[i] = r[COEF_W-1:0];
      end
      send_group(n);
    end
    wait_outputs();
  endtask

  // ====================
  // Watchdog and main
  // ====================

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("Timeout: watchdog expired after %0d cycles", WDOG_CYCLES);
    $display("FAIL: see errors above");
    $fatal(1, "watchdog");
  end

  initial begin
    rst_n    = 1'b0;
    coef_vld = 1'b0;
    coef_in  = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    test_idle_after_reset();
    test_equal_group();
    test_single_and_full();
    test_mixed_group();
    test_random_groups();

    // Trailing idle window checked by the monitor
    repeat (10) @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- verilog/exp_sum.sv
/* Exponent and group sum stage
   Decodes 2^c per beat, sums each group, feeds dividend and divisor FIFOs */
`timescale 1ns/1ps

module exp_sum (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             coef_vld,
  input  softmax_pkg::coef_beat_t          coef_in,
  output logic [softmax_pkg::EXP_W-1:0]    divd_din,
  output logic                             divd_wr,
  output softmax_pkg::dvsr_entry_t         dvsr_din,
  output logic                             dvsr_wr
);

  import softmax_pkg::*;

  logic [EXP_W-1:0]  exp_val;
  logic [NODE_W-1:0] beat_cnt;
  logic [SUM_W-1:0]  sum_acc;
  logic [SUM_W-1:0]  sum_next;
  logic              grp_last;

  // Finished group, held one cycle so the divisor trails its dividends
  dvsr_entry_t       entry_q;
  logic              entry_vld;

  // ====================
  // Exponent and sum
  // ====================

  assign exp_val  = EXP_W'(1) << coef_in.coef;

  // First beat of a group restarts the sum
  assign sum_next = (beat_cnt == '0) ? SUM_W'(exp_val) : sum_acc + SUM_W'(exp_val);
  assign grp_last = (NODE_W'(beat_cnt + 1'b1) == coef_in.num_node);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= '0;
    end else if (coef_vld) begin
      beat_cnt <= grp_last ? '0 : beat_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (coef_vld) begin
      sum_acc <= sum_next;
    end
  end

  // ====================
  // FIFO writes
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      divd_wr   <= 1'b0;
      entry_vld <= 1'b0;
      dvsr_wr   <= 1'b0;
    end else begin
      divd_wr   <= coef_vld;
      entry_vld <= coef_vld && grp_last;
      dvsr_wr   <= entry_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (coef_vld) begin
      divd_din <= exp_val;
    end
    if (coef_vld && grp_last) begin
      entry_q.num_node <= coef_in.num_node;
      entry_q.sum      <= sum_next;
    end
    // Stage two of the divisor path
    dvsr_din <= entry_q;
  end

  // Empty groups would never close
  a_num_node_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    coef_vld |-> (coef_in.num_node != '0))
    else $error("exp_sum: beat with num_node of zero");

endmodule

//--- verilog/fxp_div_pipe.sv
/* Pipelined restoring divider
   One quotient bit per stage, 1.15 result, truncated, fixed latency */
`timescale 1ns/1ps

module fxp_div_pipe (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             in_vld,
  input  logic [softmax_pkg::EXP_W-1:0]    dividend,
  input  logic [softmax_pkg::SUM_W-1:0]    divisor,
  input  logic                             last_in,
  output logic                             out_vld,
  output softmax_pkg::alpha_beat_t         out
);

  import softmax_pkg::*;

  // Partial remainder needs one bit over the divisor for the shift
  localparam int R_W = SUM_W + 1;

  // Index 0 is the input register, index k+1 is the output of stage k
  logic [R_W-1:0]     pr  [0:ALPHA_W-1];
  logic [SUM_W-1:0]   dvs [0:ALPHA_W-1];
  logic [ALPHA_W-1:0] qt  [1:ALPHA_W];
  logic               vld [0:ALPHA_W];
  logic               lst [0:ALPHA_W];

  alpha_beat_t        res_q;
  logic               res_vld;

  // ====================
  // Input register
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld[0] <= 1'b0;
    end else begin
      vld[0] <= in_vld;
    end
  end

  // Dividend already sits at the bit-15 position of dividend * 2^15
  always_ff @(posedge clk) begin
    pr[0]  <= R_W'(dividend);
    dvs[0] <= divisor;
    lst[0] <= last_in;
  end

  // ====================
  // Division stages
  // ====================

  for (genvar k = 0; k < ALPHA_W; k++) begin : g_stage
    logic [R_W-1:0] trial;
    logic           take;

    assign take  = (pr[k] >= {1'b0, dvs[k]});
    assign trial = pr[k] - {1'b0, dvs[k]};

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        vld[k+1] <= 1'b0;
      end else begin
        vld[k+1] <= vld[k];
      end
    end

    always_ff @(posedge clk) begin
      lst[k+1] <= lst[k];
    end

    // Quotient bits enter at the LSB and move up one place per stage
    if (k == 0) begin : g_first
      always_ff @(posedge clk) begin
        qt[1] <= ALPHA_W'(take);
      end
    end else begin : g_next
      always_ff @(posedge clk) begin
        qt[k+1] <= {qt[k][ALPHA_W-2:0], take};
      end
    end

    // Lower numerator bits are zero, so just shift the remainder
    if (k < ALPHA_W - 1) begin : g_fwd
      always_ff @(posedge clk) begin
        pr[k+1]  <= take ? {trial[R_W-2:0], 1'b0} : {pr[k][R_W-2:0], 1'b0};
        dvs[k+1] <= dvs[k];
      end
    end
  end

  // ====================
  // Output registers
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_vld <= 1'b0;
      out_vld <= 1'b0;
    end else begin
      res_vld <= vld[ALPHA_W];
      out_vld <= res_vld;
    end
  end

  always_ff @(posedge clk) begin
    res_q.alpha <= qt[ALPHA_W];
    res_q.last  <= lst[ALPHA_W];
    out         <= res_q;
  end

endmodule

//--- verilog/softmax.sv
/* Softmax normaliser top level
   Exponent/sum stage, dividend and divisor FIFOs, scheduler and divider */
`timescale 1ns/1ps

module softmax (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     coef_vld,
  input  softmax_pkg::coef_beat_t  coef_in,
  output logic                     alpha_vld,
  output softmax_pkg::alpha_beat_t alpha_out
);

  import softmax_pkg::*;

  // Dividend path
  logic [EXP_W-1:0]  divd_din;
  logic [EXP_W-1:0]  divd_dout;
  logic              divd_wr;
  logic              divd_rd;
  logic              divd_empty;

  // Divisor path
  dvsr_entry_t       dvsr_din;
  dvsr_entry_t       dvsr_dout;
  logic              dvsr_wr;
  logic              dvsr_rd;
  logic              dvsr_empty;

  // Scheduler
  sched_state_t      state;
  logic [NODE_W-1:0] remain;
  logic [SUM_W-1:0]  dvsr_q;
  logic              div_vld;
  logic              div_last;

  // ====================
  // Exponent and sum
  // ====================

  exp_sum u_exp_sum (
    .clk      (clk),
    .rst_n    (rst_n),
    .coef_vld (coef_vld),
    .coef_in  (coef_in),
    .divd_din (divd_din),
    .divd_wr  (divd_wr),
    .dvsr_din (dvsr_din),
    .dvsr_wr  (dvsr_wr)
  );

  sync_fifo #(
    .DEPTH (DIV_FIFO_DEPTH),
    .T     (logic [EXP_W-1:0])
  ) u_divd_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (divd_din),
    .wr    (divd_wr),
    .rd    (divd_rd),
    .dout  (divd_dout),
    .empty (divd_empty),
    .full  ()
  );

  sync_fifo #(
    .DEPTH (DIV_FIFO_DEPTH),
    .T     (dvsr_entry_t)
  ) u_dvsr_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (dvsr_din),
    .wr    (dvsr_wr),
    .rd    (dvsr_rd),
    .dout  (dvsr_dout),
    .empty (dvsr_empty),
    .full  ()
  );

  // ====================
  // Scheduler
  // ====================

  // A divisor is only written after its whole group of dividends
  assign dvsr_rd  = (state == SCHED_IDLE) && !dvsr_empty;
  assign divd_rd  = (state == SCHED_RUN);
  assign div_vld  = divd_rd;
  assign div_last = (remain == NODE_W'(1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= SCHED_IDLE;
      remain <= '0;
    end else begin
      case (state)
        SCHED_IDLE: begin
          if (dvsr_rd) begin
            state  <= SCHED_RUN;
            remain <= dvsr_dout.num_node;
          end
        end
        SCHED_RUN: begin
          remain <= remain - 1'b1;
          if (div_last) begin
            state <= SCHED_IDLE;
          end
        end
        default: state <= SCHED_IDLE;
      endcase
    end
  end

  // Group sum held for the whole run
  always_ff @(posedge clk) begin
    if (dvsr_rd) begin
      dvsr_q <= dvsr_dout.sum;
    end
  end

  fxp_div_pipe u_div (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_vld   (div_vld),
    .dividend (divd_dout),
    .divisor  (dvsr_q),
    .last_in  (div_last),
    .out_vld  (alpha_vld),
    .out      (alpha_out)
  );

  a_run_has_dividend: assert property (@(posedge clk) disable iff (!rst_n)
    (state == SCHED_RUN) |-> !divd_empty)
    else $error("softmax: dividend FIFO empty during a run");

endmodule

//--- verilog/softmax_pkg.sv
/* Softmax normaliser shared definitions
   Widths, beat structs and scheduler state */
package softmax_pkg;

  // ====================
  // Sizes
  // ====================

  // Attention coefficient and group size
  localparam int COEF_W         = 4;
  localparam int MAX_NODES      = 16;
  localparam int NODE_W         = $clog2(MAX_NODES) + 1;

  // 2^c and the sum of up to MAX_NODES terms
  localparam int EXP_W          = 16;
  localparam int SUM_W          = EXP_W + $clog2(MAX_NODES);

  // Weight format, 1.15 unsigned
  localparam int WOI            = 1;
  localparam int WOF            = 15;
  localparam int ALPHA_W        = WOI + WOF;

  // Input reg + one stage per quotient bit + two output regs
  localparam int DIV_LAT        = ALPHA_W + 3;

  // Room for two groups of the largest size
  localparam int DIV_FIFO_DEPTH = 2 * MAX_NODES;

  // ====================
  // Beats and entries
  // ====================

  typedef struct packed {
    logic [NODE_W-1:0] num_node;
    logic [COEF_W-1:0] coef;
  } coef_beat_t;

  typedef struct packed {
    logic [NODE_W-1:0] num_node;
    logic [SUM_W-1:0]  sum;
  } dvsr_entry_t;

  typedef struct packed {
    logic [ALPHA_W-1:0] alpha;
    logic               last;   // final weight of the group
  } alpha_beat_t;

  // Divider-side scheduler
  typedef enum logic [0:0] {
    SCHED_IDLE,
    SCHED_RUN
  } sched_state_t;

endpackage

//--- verilog/sync_fifo.sv
/* Show-ahead synchronous FIFO
   Circular buffer with an occupancy count, head entry always on dout */
`timescale 1ns/1ps

module sync_fifo #(
  parameter int  DEPTH = softmax_pkg::DIV_FIFO_DEPTH,
  parameter type T     = logic
) (
  input  logic clk,
  input  logic rst_n,
  input  T     din,
  input  logic wr,
  input  logic rd,
  output T     dout,
  output logic empty,
  output logic full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;

  // Wrap explicitly so non power-of-two depths work
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr, rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head of queue, valid while not empty
  assign dout  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == CW'(DEPTH));

  // Sender must stay within two groups of the divider
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(wr && full))
    else $error("sync_fifo: write while full");
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(rd && empty))
    else $error("sync_fifo: read while empty");

endmodule
